/* build.f */
+incdir+include
logic/memory_pkg.sv
logic/l1_cache.sv
logic/l2_cache.sv
logic/main_memory.sv
logic/memory_hierarchy.sv
test/tb_memory_hierarchy.sv

/* include/memory_config.svh */
// Width, depth and latency macros for the cache levels and main memory
`ifndef MEMORY_CONFIG_SVH
`define MEMORY_CONFIG_SVH

// Word and address sizes
`define ADDR_WIDTH        6
`define DATA_WIDTH        16

// L1 geometry with two ways per set
`define L1_SETS           2
`define L1_TAG_WIDTH      5    // Address bits above the set index

// Fully associative L2 geometry
`define L2_ENTRIES        8
`define L2_AGE_WIDTH      3    // Enough for true LRU over 8 entries

// Backing store
`define MEM_WORDS         64
`define MEM_READ_LATENCY  2    // Cycles from memory request to valid

`endif

/* logic/l1_cache.sv */
// Two-way set-associative L1 cache with the request front end
`timescale 1ns/100ps
`include "memory_config.svh"

module l1_cache
  import memory_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   i_read,           // One-cycle read strobe
  input  logic                   i_write,          // One-cycle write strobe
  input  logic [`ADDR_WIDTH-1:0] i_address,
  input  logic [`DATA_WIDTH-1:0] i_write_data,
  output logic [`DATA_WIDTH-1:0] o_read_data,      // Held until next done
  output logic                   o_hit_l1,
  output logic                   o_hit_l2,
  output logic                   o_done,           // Pulse at end of access
  output logic                   o_busy,
  output logic                   o_l2_req,         // Strobe towards L2
  output cache_op_t              o_l2_op,
  output logic [`ADDR_WIDTH-1:0] o_l2_address,
  output logic [`DATA_WIDTH-1:0] o_l2_write_data,
  input  logic                   i_l2_done,
  input  logic [`DATA_WIDTH-1:0] i_l2_data,
  input  logic                   i_l2_hit
);

  // Arrays indexed [set][way]
  logic [`DATA_WIDTH-1:0]   l1_data  [`L1_SETS][2];
  logic [`L1_TAG_WIDTH-1:0] l1_tag   [`L1_SETS][2];
  logic                     l1_valid [`L1_SETS][2];
  logic                     l1_lru   [`L1_SETS][2];   // Set means next victim

  l1_state_t              state;
  logic                   hit_pending;   // Read hit whose done goes out next cycle
  logic                   req_hit;       // L1 lookup result of access in flight
  logic [`DATA_WIDTH-1:0] req_data;      // Hit word or word being written

  logic [`ADDR_WIDTH-1:0]               look_address;
  logic [`ADDR_WIDTH-`L1_TAG_WIDTH-1:0] look_set;
  logic [`L1_TAG_WIDTH-1:0]             look_tag;
  logic                                 hit_way0;
  logic                                 hit_way1;
  logic                                 look_hit;
  logic                                 way_sel;
  logic                                 new_req;
  logic                                 fill_en;
  logic                                 store_en;
  logic                                 touch_en;
  logic [`DATA_WIDTH-1:0]               store_word;

  // While waiting on L2 the held request address drives the lookup
  assign look_address = (state == L1_WAIT_L2) ? o_l2_address : i_address;
  assign look_set     = look_address[`ADDR_WIDTH-`L1_TAG_WIDTH-1:0];
  assign look_tag     = look_address[`ADDR_WIDTH-1 -: `L1_TAG_WIDTH];

  assign hit_way0 = l1_valid[look_set][0] && (l1_tag[look_set][0] == look_tag);
  assign hit_way1 = l1_valid[look_set][1] && (l1_tag[look_set][1] == look_tag);
  assign look_hit = hit_way0 || hit_way1;

  // Matching way, then first free way, then the LRU way
  always_comb
  begin
    if (hit_way0)
      way_sel = 1'b0;
    else if (hit_way1)
      way_sel = 1'b1;
    else if (!l1_valid[look_set][0])
      way_sel = 1'b0;
    else if (!l1_valid[look_set][1])
      way_sel = 1'b1;
    else
      way_sel = l1_lru[look_set][1];
  end

  assign new_req    = (i_read || i_write) && !o_busy;
  assign fill_en    = (state == L1_WAIT_L2) && i_l2_done && (o_l2_op == OP_READ);
  assign store_en   = (new_req && i_write) || fill_en;       // Write allocate or read fill
  assign touch_en   = (new_req && (i_write || look_hit)) || fill_en;
  assign store_word = fill_en ? i_l2_data : i_write_data;

  // Data and tag storage
  always_ff @(posedge clock)
  begin
    if (store_en)
    begin
      l1_data[look_set][way_sel] <= store_word;
      l1_tag[look_set][way_sel]  <= look_tag;
    end
  end

  // Valid and LRU bits
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < `L1_SETS; s++)
      begin
        l1_valid[s][0] <= 1'b0;
        l1_valid[s][1] <= 1'b0;
        l1_lru[s][0]   <= 1'b0;
        l1_lru[s][1]   <= 1'b0;
      end
    end
    else
    begin
      if (store_en)
        l1_valid[look_set][way_sel] <= 1'b1;
      if (touch_en)
      begin
        l1_lru[look_set][way_sel]  <= 1'b0;                         // Most recent
        l1_lru[look_set][~way_sel] <= l1_valid[look_set][~way_sel]; // Other way ages if used
      end
    end
  end

  // Front-end FSM and status flags
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state       <= L1_IDLE;
      hit_pending <= 1'b0;
      req_hit     <= 1'b0;
      o_done      <= 1'b0;
      o_busy      <= 1'b0;
      o_hit_l1    <= 1'b0;
      o_hit_l2    <= 1'b0;
      o_l2_req    <= 1'b0;
    end
    else
    begin
      o_done      <= 1'b0;
      o_l2_req    <= 1'b0;
      hit_pending <= 1'b0;
      if (new_req)
      begin
        o_busy  <= 1'b1;
        req_hit <= look_hit;
        if (i_write || !look_hit)
        begin
          o_l2_req <= 1'b1;   // Write-through, or fetch on miss
          state    <= L1_WAIT_L2;
        end
        else
          hit_pending <= 1'b1;
      end
      else if (hit_pending)
      begin
        o_done   <= 1'b1;
        o_busy   <= 1'b0;
        o_hit_l1 <= 1'b1;
        o_hit_l2 <= 1'b0;
      end
      else if ((state == L1_WAIT_L2) && i_l2_done)
      begin
        state    <= L1_IDLE;
        o_done   <= 1'b1;
        o_busy   <= 1'b0;
        o_hit_l1 <= req_hit;
        o_hit_l2 <= (o_l2_op == OP_READ) && i_l2_hit;   // Writes report L1 only
      end
    end
  end

  // Request fields and returned word
  always_ff @(posedge clock)
  begin
    if (new_req)
    begin
      req_data        <= i_write ? i_write_data : l1_data[look_set][way_sel];
      o_l2_op         <= i_write ? OP_WRITE : OP_READ;
      o_l2_address    <= i_address;
      o_l2_write_data <= i_write_data;
    end
    if (hit_pending || ((state == L1_WAIT_L2) && i_l2_done && (o_l2_op == OP_WRITE)))
      o_read_data <= req_data;      // Hit word, or echo of the write
    else if (fill_en)
      o_read_data <= i_l2_data;
  end

  // Caller never raises both strobes
  a_one_strobe: assert property (@(posedge clock) disable iff (reset)
    !(i_read && i_write));

  // One access in flight
  a_no_req_busy: assert property (@(posedge clock) disable iff (reset)
    o_busy |-> !(i_read || i_write));

  // L2 only answers an outstanding request
  a_l2_done_wait: assert property (@(posedge clock) disable iff (reset)
    i_l2_done |-> (state == L1_WAIT_L2));

endmodule

/* logic/l2_cache.sv */
// Eight-entry fully associative L2 cache with age-based true LRU
`timescale 1ns/100ps
`include "memory_config.svh"

module l2_cache
  import memory_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   i_l2_req,          // Strobe from L1
  input  cache_op_t              i_l2_op,
  input  logic [`ADDR_WIDTH-1:0] i_l2_address,
  input  logic [`DATA_WIDTH-1:0] i_l2_write_data,
  output logic                   o_l2_done,         // Pulse back to L1
  output logic [`DATA_WIDTH-1:0] o_l2_data,
  output logic                   o_l2_hit,
  output logic                   o_mem_req,         // Strobe to memory
  output cache_op_t              o_mem_op,
  output logic [`ADDR_WIDTH-1:0] o_mem_address,
  output logic [`DATA_WIDTH-1:0] o_mem_write_data,
  input  logic                   i_mem_valid,       // Read data valid pulse
  input  logic [`DATA_WIDTH-1:0] i_mem_data
);

  typedef logic [$clog2(`L2_ENTRIES)-1:0] index_t;

  logic [`DATA_WIDTH-1:0]   l2_data  [`L2_ENTRIES];
  logic [`ADDR_WIDTH-1:0]   l2_tag   [`L2_ENTRIES];   // Full address
  logic                     l2_valid [`L2_ENTRIES];
  logic [`L2_AGE_WIDTH-1:0] l2_age   [`L2_ENTRIES];   // 0 is most recent

  l2_state_t state;

  logic [`ADDR_WIDTH-1:0]   look_address;
  logic                     look_hit;
  index_t                   hit_index;
  logic                     have_free;
  index_t                   free_index;
  index_t                   old_index;
  index_t                   victim;
  logic [`L2_AGE_WIDTH-1:0] touch_old_age;
  logic                     accept;
  logic                     mem_fill;
  logic                     store_en;
  logic                     touch_en;
  logic [`DATA_WIDTH-1:0]   store_word;
  logic                     dup_address;

  // Held memory address keys the lookup during a refill
  assign look_address = (state == L2_WAIT_MEM) ? o_mem_address : i_l2_address;

  // Associative search, lowest free entry, oldest entry
  always_comb
  begin
    look_hit   = 1'b0;
    hit_index  = '0;
    have_free  = 1'b0;
    free_index = '0;
    old_index  = '0;
    for (int i = `L2_ENTRIES - 1; i >= 0; i--)   // Descending so lowest index wins
    begin
      if (l2_valid[i] && (l2_tag[i] == look_address))
      begin
        look_hit  = 1'b1;
        hit_index = index_t'(i);
      end
      if (!l2_valid[i])
      begin
        have_free  = 1'b1;
        free_index = index_t'(i);
      end
    end
    for (int i = 1; i < `L2_ENTRIES; i++)
      if (l2_age[i] > l2_age[old_index])
        old_index = index_t'(i);
  end

  assign victim = look_hit ? hit_index : (have_free ? free_index : old_index);

  // New fills count as the oldest possible age
  assign touch_old_age = l2_valid[victim] ? l2_age[victim] : {`L2_AGE_WIDTH{1'b1}};

  assign accept     = (state == L2_IDLE) && i_l2_req;
  assign mem_fill   = (state == L2_WAIT_MEM) && i_mem_valid;
  assign store_en   = (accept && (i_l2_op == OP_WRITE)) || mem_fill;
  assign touch_en   = (accept && ((i_l2_op == OP_WRITE) || look_hit)) || mem_fill;
  assign store_word = mem_fill ? i_mem_data : i_l2_write_data;

  // Entry payload
  always_ff @(posedge clock)
  begin
    if (store_en)
    begin
      l2_data[victim] <= store_word;
      l2_tag[victim]  <= look_address;
    end
  end

  // Valid bits and ages
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `L2_ENTRIES; i++)
      begin
        l2_valid[i] <= 1'b0;
        l2_age[i]   <= '0;
      end
    end
    else
    begin
      if (store_en)
        l2_valid[victim] <= 1'b1;
      if (touch_en)
      begin
        for (int i = 0; i < `L2_ENTRIES; i++)
        begin
          if (index_t'(i) == victim)
            l2_age[i] <= '0;
          else if (l2_valid[i] && (l2_age[i] < touch_old_age))
            l2_age[i] <= l2_age[i] + 1'b1;   // Younger entries move back one
        end
      end
    end
  end

  // Controller FSM
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state     <= L2_IDLE;
      o_l2_done <= 1'b0;
      o_l2_hit  <= 1'b0;
      o_mem_req <= 1'b0;
    end
    else
    begin
      o_l2_done <= 1'b0;
      o_mem_req <= 1'b0;
      if (accept)
      begin
        if (i_l2_op == OP_WRITE)
        begin
          o_mem_req <= 1'b1;   // Write-through with no answer from memory
          o_l2_done <= 1'b1;
          o_l2_hit  <= look_hit;
        end
        else if (look_hit)
        begin
          o_l2_done <= 1'b1;
          o_l2_hit  <= 1'b1;
        end
        else
        begin
          o_mem_req <= 1'b1;
          state     <= L2_WAIT_MEM;
        end
      end
      else if (mem_fill)
      begin
        state     <= L2_IDLE;
        o_l2_done <= 1'b1;
        o_l2_hit  <= 1'b0;
      end
    end
  end

  // Memory request fields and data back to L1
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      o_mem_op         <= i_l2_op;
      o_mem_address    <= i_l2_address;
      o_mem_write_data <= i_l2_write_data;
      o_l2_data        <= (i_l2_op == OP_WRITE) ? i_l2_write_data : l2_data[hit_index];
    end
    else if (mem_fill)
      o_l2_data <= i_mem_data;
  end

  // Any two valid entries holding one address
  always_comb
  begin
    dup_address = 1'b0;
    for (int i = 0; i < `L2_ENTRIES; i++)
      for (int j = i + 1; j < `L2_ENTRIES; j++)
        if (l2_valid[i] && l2_valid[j] && (l2_tag[i] == l2_tag[j]))
          dup_address = 1'b1;
  end

  a_unique_address: assert property (@(posedge clock) disable iff (reset)
    !dup_address);

  // Memory answers only the outstanding read miss
  a_mem_valid_wait: assert property (@(posedge clock) disable iff (reset)
    i_mem_valid |-> (state == L2_WAIT_MEM));

endmodule

/* logic/main_memory.sv */
// 64-word backing store with fixed read latency
`timescale 1ns/100ps
`include "memory_config.svh"

module main_memory
  import memory_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   i_mem_req,
  input  cache_op_t              i_mem_op,
  input  logic [`ADDR_WIDTH-1:0] i_mem_address,
  input  logic [`DATA_WIDTH-1:0] i_mem_write_data,
  output logic                   o_mem_valid,      // One pulse per read
  output logic [`DATA_WIDTH-1:0] o_mem_data
);

  typedef logic [$clog2(`MEM_READ_LATENCY + 1)-1:0] count_t;

  logic [`DATA_WIDTH-1:0] mem [`MEM_WORDS];
  logic                   read_pending;
  count_t                 read_count;      // Cycles left before valid
  logic [`ADDR_WIDTH-1:0] read_address;
  logic                   read_due;

  assign read_due = read_pending && (read_count < count_t'(2));

  // Array, cleared on reset, and read latency counter
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MEM_WORDS; i++)
        mem[i] <= '0;
      read_pending <= 1'b0;
      read_count   <= '0;
      o_mem_valid  <= 1'b0;
    end
    else
    begin
      o_mem_valid <= 1'b0;
      if (i_mem_req && (i_mem_op == OP_WRITE))
        mem[i_mem_address] <= i_mem_write_data;   // Stored in the request cycle
      if (i_mem_req && (i_mem_op == OP_READ))
      begin
        read_pending <= 1'b1;
        read_count   <= count_t'(`MEM_READ_LATENCY - 1);   // Request cycle counts as one
      end
      else if (read_due)
      begin
        read_pending <= 1'b0;
        o_mem_valid  <= 1'b1;
      end
      else if (read_pending)
        read_count <= read_count - 1'b1;
    end
  end

  // Read address and returned word
  always_ff @(posedge clock)
  begin
    if (i_mem_req && (i_mem_op == OP_READ))
      read_address <= i_mem_address;
    if (read_due)
      o_mem_data <= mem[read_address];
  end

  // L2 holds off until the read returns
  a_no_req_pending: assert property (@(posedge clock) disable iff (reset)
    i_mem_req |-> !read_pending);

endmodule

/* logic/memory_hierarchy.sv */
// Top level joining L1, L2 and main memory
`timescale 1ns/100ps
`include "memory_config.svh"

module memory_hierarchy
  import memory_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   i_read,
  input  logic                   i_write,
  input  logic [`ADDR_WIDTH-1:0] i_address,
  input  logic [`DATA_WIDTH-1:0] i_write_data,
  output logic [`DATA_WIDTH-1:0] o_read_data,
  output logic                   o_hit_l1,
  output logic                   o_hit_l2,
  output logic                   o_done,
  output logic                   o_busy
);

  // L1 <-> L2
  logic                   l2_req;
  cache_op_t              l2_op;
  logic [`ADDR_WIDTH-1:0] l2_address;
  logic [`DATA_WIDTH-1:0] l2_write_data;
  logic                   l2_done;
  logic [`DATA_WIDTH-1:0] l2_data;
  logic                   l2_hit;

  // L2 <-> memory
  logic                   mem_req;
  cache_op_t              mem_op;
  logic [`ADDR_WIDTH-1:0] mem_address;
  logic [`DATA_WIDTH-1:0] mem_write_data;
  logic                   mem_valid;
  logic [`DATA_WIDTH-1:0] mem_data;

  l1_cache i_l1_cache
  (
    .clock           (clock),
    .reset           (reset),
    .i_read          (i_read),
    .i_write         (i_write),
    .i_address       (i_address),
    .i_write_data    (i_write_data),
    .o_read_data     (o_read_data),
    .o_hit_l1        (o_hit_l1),
    .o_hit_l2        (o_hit_l2),
    .o_done          (o_done),
    .o_busy          (o_busy),
    .o_l2_req        (l2_req),
    .o_l2_op         (l2_op),
    .o_l2_address    (l2_address),
    .o_l2_write_data (l2_write_data),
    .i_l2_done       (l2_done),
    .i_l2_data       (l2_data),
    .i_l2_hit        (l2_hit)
  );

  l2_cache i_l2_cache
  (
    .clock            (clock),
    .reset            (reset),
    .i_l2_req         (l2_req),
    .i_l2_op          (l2_op),
    .i_l2_address     (l2_address),
    .i_l2_write_data  (l2_write_data),
    .o_l2_done        (l2_done),
    .o_l2_data        (l2_data),
    .o_l2_hit         (l2_hit),
    .o_mem_req        (mem_req),
    .o_mem_op         (mem_op),
    .o_mem_address    (mem_address),
    .o_mem_write_data (mem_write_data),
    .i_mem_valid      (mem_valid),
    .i_mem_data       (mem_data)
  );

  main_memory i_main_memory
  (
    .clock            (clock),
    .reset            (reset),
    .i_mem_req        (mem_req),
    .i_mem_op         (mem_op),
    .i_mem_address    (mem_address),
    .i_mem_write_data (mem_write_data),
    .o_mem_valid      (mem_valid),
    .o_mem_data       (mem_data)
  );

endmodule

/* logic/memory_pkg.sv */
// Package with the cache operation enum and the L1 and L2 FSM state enums
package memory_pkg;

  // Operation passed L1 -> L2 and L2 -> memory
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_t;

  // L1 front end
  typedef enum logic
  {
    L1_IDLE    = 1'b0,   // Accepting requests
    L1_WAIT_L2 = 1'b1    // Write or read miss outstanding in L2
  } l1_state_t;

  // L2 controller
  typedef enum logic
  {
    L2_IDLE     = 1'b0,
    L2_WAIT_MEM = 1'b1   // Read miss waiting on main memory
  } l2_state_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory hierarchy testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_memory_hierarchy -f build.f -o sim_memory_hierarchy

output=$(./obj_dir/sim_memory_hierarchy)
echo "$output"

if grep -qx "Verification passed" <<< "$output"; then
  exit 0
fi
exit 1

/* test/hierarchy_cases.txt */
# Columns: op (0 read, 1 write), address, write data, expected o_read_data, o_hit_l1, o_hit_l2
# All values in hex; memory starts at zero
# Cold read misses everywhere, then hits L1
0 04 0000 0000 0 0
0 04 0000 0000 1 0
# Write hit in L1, read back
1 04 5a5a 5a5a 1 0
0 04 0000 5a5a 1 0
# Write miss allocates way 1 of set 0
1 06 1234 1234 0 0
0 06 0000 1234 1 0
# Third address in set 0 evicts 04, which comes back from L2
0 08 0000 0000 0 0
0 04 0000 5a5a 0 1
0 08 0000 0000 1 0
0 06 0000 1234 0 1
# Nine writes fill L2 and push out 08, 04, 06 and 11
1 11 a011 a011 0 0
1 13 a013 a013 0 0
1 15 a015 a015 0 0
1 17 a017 a017 0 0
1 19 a019 a019 0 0
1 1b a01b a01b 0 0
1 1d a01d a01d 0 0
1 1f a01f a01f 0 0
1 21 a021 a021 0 0
# Evicted addresses come from memory
0 11 0000 a011 0 0
0 04 0000 5a5a 0 0
# Still in L2, then in L1
0 1f 0000 a01f 0 1
0 1f 0000 a01f 1 0
# Write that hits L2 only still reports o_hit_l2 low
1 21 beef beef 0 0
0 21 0000 beef 1 0
0 11 0000 a011 0 1
0 17 0000 a017 0 1

/* test/tb_memory_hierarchy.sv */
// Testbench with clock, reset, case file replay and result checks
`timescale 1ns/100ps
`include "memory_config.svh"

module tb_memory_hierarchy;

  localparam int TIMEOUT_CYCLES = 50;   // Per access and far above the slowest read

  logic                   clock;
  logic                   reset;
  logic                   i_read;
  logic                   i_write;
  logic [`ADDR_WIDTH-1:0] i_address;
  logic [`DATA_WIDTH-1:0] i_write_data;
  logic [`DATA_WIDTH-1:0] o_read_data;
  logic                   o_hit_l1;
  logic                   o_hit_l2;
  logic                   o_done;
  logic                   o_busy;

  int pass_count;
  int fail_count;
  bit timed_out;

  memory_hierarchy i_dut
  (
    .clock        (clock),
    .reset        (reset),
    .i_read       (i_read),
    .i_write      (i_write),
    .i_address    (i_address),
    .i_write_data (i_write_data),
    .o_read_data  (o_read_data),
    .o_hit_l1     (o_hit_l1),
    .o_hit_l2     (o_hit_l2),
    .o_done       (o_done),
    .o_busy       (o_busy)
  );

  // 4 ns period
  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Cycles from the sampling edge to o_done for each source of the word
  function automatic int expected_latency(input logic is_write, input logic hit_l1,
                                          input logic hit_l2);
    if (is_write)
      return 2;                         // L1 update, then L2 forwards to memory
    else if (hit_l1)
      return 1;
    else if (hit_l2)
      return 2;
    return 3 + `MEM_READ_LATENCY;       // L1 -> L2 -> memory and back
  endfunction

  // One-cycle strobe driven 1 ns after the edge
  task automatic drive_strobe(input logic is_write, input logic [`ADDR_WIDTH-1:0] address,
                              input logic [`DATA_WIDTH-1:0] data);
    @(posedge clock);
    #1;
    i_read       = !is_write;
    i_write      = is_write;
    i_address    = address;
    i_write_data = data;
    @(posedge clock);                   // DUT samples the request here
    #1;
    i_read  = 1'b0;
    i_write = 1'b0;
  endtask

  // Polls o_done once per cycle and tracks o_busy on the way
  task automatic wait_for_done(output int cycles, output bit busy_ok, output bit done_seen);
    cycles    = 0;
    busy_ok   = o_busy;                 // Busy must already be up
    done_seen = 1'b0;
    while (!done_seen && (cycles < TIMEOUT_CYCLES))
    begin
      @(posedge clock);
      #1;
      cycles++;
      if (o_done)
        done_seen = 1'b1;
      else if (!o_busy)
        busy_ok = 1'b0;
    end
  endtask

  // Runs one access and compares against the case file
  task automatic check_access(input int index, input logic is_write,
                              input logic [`ADDR_WIDTH-1:0] address,
                              input logic [`DATA_WIDTH-1:0] data,
                              input logic [`DATA_WIDTH-1:0] exp_data,
                              input logic exp_hit_l1, input logic exp_hit_l2);
    int cycles;
    int exp_cycles;
    int errors;
    bit busy_ok;
    bit done_seen;
    errors     = 0;
    exp_cycles = expected_latency(is_write, exp_hit_l1, exp_hit_l2);
    drive_strobe(is_write, address, data);
    wait_for_done(cycles, busy_ok, done_seen);
    if (!done_seen)
    begin
      $display("Case %0d: no done pulse within %0d cycles of the request", index, cycles);
      timed_out = 1'b1;
      fail_count++;
    end
    else
    begin
      assert (o_read_data === exp_data)
      else
      begin
        $display("MISMATCH case %0d o_read_data: got %h, expected %h", index, o_read_data,
                 exp_data);
        errors++;
      end
      assert (o_hit_l1 === exp_hit_l1)
      else
      begin
        $display("MISMATCH case %0d o_hit_l1: got %h, expected %h", index, o_hit_l1,
                 exp_hit_l1);
        errors++;
      end
      assert (o_hit_l2 === exp_hit_l2)
      else
      begin
        $display("MISMATCH case %0d o_hit_l2: got %h, expected %h", index, o_hit_l2,
                 exp_hit_l2);
        errors++;
      end
      assert (o_busy === 1'b0)
      else
      begin
        $display("MISMATCH case %0d o_busy at done: got %h, expected %h", index, o_busy, 1'b0);
        errors++;
      end
      assert (busy_ok)
      else
      begin
        $display("Case %0d: o_busy was low while the access was in flight", index);
        errors++;
      end
      assert (cycles == exp_cycles)
      else
      begin
        $display("Case %0d: o_done came %0d cycles after the request instead of %0d", index,
                 cycles, exp_cycles);
        errors++;
      end
      if (errors == 0)
        pass_count++;
      else
        fail_count++;
      $display("Case %0d: %s %h data %h hit_l1 %0b hit_l2 %0b in %0d cycles %s", index,
               is_write ? "write" : "read ", address, o_read_data, o_hit_l1, o_hit_l2, cycles,
               (errors == 0) ? "ok" : "FAIL");
    end
  endtask

  // Case replay
  initial
  begin
    int                     fd;
    int                     n;
    int                     gap;
    int                     index;
    string                  line;
    logic                   op_write;
    logic [`ADDR_WIDTH-1:0] address;
    logic [`DATA_WIDTH-1:0] wdata;
    logic [`DATA_WIDTH-1:0] rdata;
    logic                   exp_h1;
    logic                   exp_h2;
    pass_count   = 0;
    fail_count   = 0;
    timed_out    = 1'b0;
    index        = 0;
    void'($urandom(32'hec46d2b2));
    reset        = 1'b1;
    i_read       = 1'b0;
    i_write      = 1'b0;
    i_address    = '0;
    i_write_data = '0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;

    fd = $fopen("test/hierarchy_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file test/hierarchy_cases.txt");
      fail_count++;
    end
    else
    begin
      while (!timed_out && !$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if ((line.len() == 0) || (line[0] == "#"))
          continue;                     // Column notes and blank tail
        n = $sscanf(line, "%h %h %h %h %h %h", op_write, address, wdata, rdata, exp_h1,
                    exp_h2);
        if (n != 6)
          continue;
        gap = $urandom % 4;             // Idle cycles between accesses
        repeat (gap) @(posedge clock);
        check_access(index, op_write, address, wdata, rdata, exp_h1, exp_h2);
        index++;
      end
      $fclose(fd);
    end

    if (index == 0)
    begin
      $display("No cases were read from the case file");
      fail_count++;
    end
    $display("Summary: %0d cases ok, %0d cases with errors", pass_count, fail_count);
    if ((fail_count == 0) && !timed_out)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule
